//--- logic/memsys_consts.svh
`ifndef MEMSYS_CONSTS_SVH
`define MEMSYS_CONSTS_SVH

// Widths of a data word and of a whole cache line.
`define MEMSYS_WORD_BITS 16
`define MEMSYS_LINE_BITS 256

// A byte address splits into tag, index, word offset and byte select.
// The byte select is address bit 0.
`define MEMSYS_OFFSET_BITS 4  // Word within the line at bits 4 to 1.
`define MEMSYS_INDEX_BITS 3   // Line index at bits 7 to 5.
`define MEMSYS_TAG_BITS 8     // Tag at bits 15 to 8.

// Both caches are direct-mapped with this many lines.
`define MEMSYS_LINES 8

`endif

//--- logic/memsys_pkg.sv
`include "memsys_consts.svh"

package memsys_pkg;

	// A data word. Byte addresses use the same type.
	typedef logic [`MEMSYS_WORD_BITS-1:0] word_t;

	// A full cache line with word 0 in the low bits.
	typedef logic [`MEMSYS_LINE_BITS-1:0] block_t;

	// One enable per byte of a word. Bit 0 selects the low byte.
	typedef logic [1:0] wmask_t;

	// Cache controller states.
	// The instruction cache never writes back, so it only uses idle and fill.
	typedef enum logic [1:0] {
		s_idle,
		s_writeback,  // Old dirty line goes out to memory.
		s_fill        // New line comes in from memory.
	} cache_state_e;

	// Arbiter grant states.
	typedef enum logic [1:0] {
		s_free,
		s_icache,
		s_dcache
	} arb_state_e;

endpackage : memsys_pkg

//--- logic/mem_bus_if.sv
`timescale 1ns/1ns

// Line request bus between an L1 cache and the memory arbiter.
// A request stays up with stable address and data until resp pulses.
interface mem_bus_if import memsys_pkg::*; ();

	logic read;
	logic write;
	word_t address;   // Always line aligned.
	block_t wdata;
	block_t rdata;    // Valid in the resp cycle.
	logic resp;

	modport client (
		output read, write, address, wdata,
		input rdata, resp
	);

	modport server (
		input read, write, address, wdata,
		output rdata, resp
	);

endinterface : mem_bus_if

//--- logic/icache.sv
`timescale 1ns/1ns
`include "memsys_consts.svh"

module icache import memsys_pkg::*; (
	input logic clk,
	input logic reset,

	input logic i_read,
	input word_t i_address,
	output logic i_resp,
	output word_t i_rdata,

	mem_bus_if.client bus
);

	localparam int ADDR_MSB = $bits(word_t) - 1;
	localparam int LOW_BITS = `MEMSYS_OFFSET_BITS + 1;  // Offset plus byte select.

	block_t data_array [`MEMSYS_LINES];
	logic [`MEMSYS_TAG_BITS-1:0] tag_array [`MEMSYS_LINES];
	logic [`MEMSYS_LINES-1:0] valid;
	cache_state_e state;

	logic [`MEMSYS_TAG_BITS-1:0] tag;
	logic [`MEMSYS_INDEX_BITS-1:0] index;
	logic [`MEMSYS_OFFSET_BITS-1:0] offset;
	logic hit;
	logic take_hit;
	word_t hit_word;

	// Split the held request address into its fields.
	assign tag = i_address[ADDR_MSB -: `MEMSYS_TAG_BITS];
	assign index = i_address[LOW_BITS +: `MEMSYS_INDEX_BITS];
	assign offset = i_address[1 +: `MEMSYS_OFFSET_BITS];

	assign hit = valid[index] && (tag_array[index] == tag);
	assign hit_word = data_array[index][offset*$bits(word_t) +: $bits(word_t)];

	// A request is answered once. In the cycle where resp is high the
	// client still shows the old request, so it must not be taken again.
	assign take_hit = (state == s_idle) && i_read && !i_resp && hit;

	// The fill request goes out for as long as the FSM sits in s_fill.
	assign bus.read = (state == s_fill);
	assign bus.write = 1'b0;  // Read-only cache.
	assign bus.address = {i_address[ADDR_MSB:LOW_BITS], {LOW_BITS{1'b0}}};
	assign bus.wdata = '0;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_idle;
			valid <= '0;
			i_resp <= 1'b0;
		end else begin
			i_resp <= 1'b0;
			case (state)
				s_idle: begin
					if (take_hit)
						i_resp <= 1'b1;
					else if (i_read && !i_resp && !hit)
						state <= s_fill;  // A miss fetches the line.
				end
				s_fill: begin
					if (bus.resp) begin
						valid[index] <= 1'b1;
						state <= s_idle;  // The held request hits next cycle.
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	// Line storage and the hit data register.
	always_ff @(posedge clk) begin
		if (state == s_fill && bus.resp) begin
			data_array[index] <= bus.rdata;
			tag_array[index] <= tag;
		end
		if (take_hit)
			i_rdata <= hit_word;
	end

endmodule : icache

//--- logic/dcache.sv
`timescale 1ns/1ns
`include "memsys_consts.svh"

module dcache import memsys_pkg::*; (
	input logic clk,
	input logic reset,

	input logic d_read,
	input logic d_write,
	input word_t d_address,
	input word_t d_wdata,
	input wmask_t d_byte_enable,
	output logic d_resp,
	output word_t d_rdata,

	mem_bus_if.client bus
);

	localparam int ADDR_MSB = $bits(word_t) - 1;
	localparam int LOW_BITS = `MEMSYS_OFFSET_BITS + 1;
	localparam int WORD_BITS = $bits(word_t);

	block_t data_array [`MEMSYS_LINES];
	logic [`MEMSYS_TAG_BITS-1:0] tag_array [`MEMSYS_LINES];
	logic [`MEMSYS_LINES-1:0] valid;
	logic [`MEMSYS_LINES-1:0] dirty;
	cache_state_e state;

	logic [`MEMSYS_TAG_BITS-1:0] tag;
	logic [`MEMSYS_INDEX_BITS-1:0] index;
	logic [`MEMSYS_OFFSET_BITS-1:0] offset;
	logic request;
	logic hit;
	logic take_hit;
	word_t hit_word;
	word_t merged_word;
	word_t victim_address;
	word_t fill_address;

	assign tag = d_address[ADDR_MSB -: `MEMSYS_TAG_BITS];
	assign index = d_address[LOW_BITS +: `MEMSYS_INDEX_BITS];
	assign offset = d_address[1 +: `MEMSYS_OFFSET_BITS];

	assign request = d_read || d_write;
	assign hit = valid[index] && (tag_array[index] == tag);
	assign take_hit = (state == s_idle) && request && !d_resp && hit;
	assign hit_word = data_array[index][offset*WORD_BITS +: WORD_BITS];

	// Only the enabled bytes of the store replace the stored word.
	always_comb begin
		merged_word = hit_word;
		for (int b = 0; b < $bits(wmask_t); b++) begin
			if (d_byte_enable[b])
				merged_word[b*8 +: 8] = d_wdata[b*8 +: 8];
		end
	end

	// The victim's address is rebuilt from its stored tag and the index.
	assign victim_address = {tag_array[index], index, {LOW_BITS{1'b0}}};
	assign fill_address = {d_address[ADDR_MSB:LOW_BITS], {LOW_BITS{1'b0}}};

	assign bus.read = (state == s_fill);
	assign bus.write = (state == s_writeback);
	assign bus.address = (state == s_writeback) ? victim_address : fill_address;
	assign bus.wdata = data_array[index];  // Only sampled during writeback.

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= s_idle;
			valid <= '0;
			dirty <= '0;
			d_resp <= 1'b0;
		end else begin
			d_resp <= 1'b0;
			case (state)
				s_idle: begin
					if (take_hit) begin
						d_resp <= 1'b1;
						if (d_write)
							dirty[index] <= 1'b1;
					end else if (request && !d_resp && !hit) begin
						// A dirty victim has to leave before the new line arrives.
						if (valid[index] && dirty[index])
							state <= s_writeback;
						else
							state <= s_fill;
					end
				end
				s_writeback: begin
					if (bus.resp)
						state <= s_fill;
				end
				s_fill: begin
					if (bus.resp) begin
						valid[index] <= 1'b1;
						dirty[index] <= 1'b0;  // Fresh copy matches memory.
						state <= s_idle;
					end
				end
				default: state <= s_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == s_fill && bus.resp) begin
			data_array[index] <= bus.rdata;
			tag_array[index] <= tag;
		end
		if (take_hit && d_write)
			data_array[index][offset*WORD_BITS +: WORD_BITS] <= merged_word;
		if (take_hit)
			d_rdata <= hit_word;  // Old contents on a store.
	end

endmodule : dcache

//--- logic/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter import memsys_pkg::*; (
	input logic clk,
	input logic reset,

	mem_bus_if.server ibus,
	mem_bus_if.server dbus,

	output logic pmem_read,
	output logic pmem_write,
	output word_t pmem_address,
	output block_t pmem_wdata,
	input logic pmem_resp,
	input block_t pmem_rdata
);

	arb_state_e state;
	arb_state_e next_state;

	logic ireq;
	logic dreq;
	logic grant_i;
	logic grant_d;

	assign ireq = ibus.read || ibus.write;
	assign dreq = dbus.read || dbus.write;

	// The grant is decided in the same cycle the request shows up.
	// When the port is free the data cache goes first.
	always_comb begin
		grant_i = 1'b0;
		grant_d = 1'b0;
		case (state)
			s_free: begin
				if (dreq)
					grant_d = 1'b1;
				else if (ireq)
					grant_i = 1'b1;
			end
			s_icache: grant_i = 1'b1;
			s_dcache: grant_d = 1'b1;
			default: ;
		endcase
	end

	// Hold the grant until memory answers.
	always_comb begin
		next_state = state;
		if (pmem_resp)
			next_state = s_free;
		else if (grant_d)
			next_state = s_dcache;
		else if (grant_i)
			next_state = s_icache;
	end

	always_ff @(posedge clk) begin
		if (reset)
			state <= s_free;
		else
			state <= next_state;
	end

	assign pmem_read = grant_d ? dbus.read : (grant_i && ibus.read);
	assign pmem_write = grant_d ? dbus.write : (grant_i && ibus.write);
	assign pmem_address = grant_d ? dbus.address : ibus.address;
	assign pmem_wdata = grant_d ? dbus.wdata : ibus.wdata;

	// The waiting cache sees neither resp nor data.
	assign ibus.resp = grant_i && pmem_resp;
	assign dbus.resp = grant_d && pmem_resp;
	assign ibus.rdata = grant_i ? pmem_rdata : '0;
	assign dbus.rdata = grant_d ? pmem_rdata : '0;

endmodule : mem_arbiter

//--- logic/memsys_top.sv
`timescale 1ns/1ns

module memsys_top import memsys_pkg::*; (
	input logic clk,
	input logic reset,

	// Instruction fetch port.
	input logic i_read,
	input word_t i_address,
	output logic i_resp,
	output word_t i_rdata,

	// Data load and store port.
	input logic d_read,
	input logic d_write,
	input word_t d_address,
	input word_t d_wdata,
	input wmask_t d_byte_enable,
	output logic d_resp,
	output word_t d_rdata,

	// Physical memory port that moves one line per transfer.
	output logic pmem_read,
	output logic pmem_write,
	output word_t pmem_address,
	output block_t pmem_wdata,
	input logic pmem_resp,
	input block_t pmem_rdata
);

	mem_bus_if ibus ();
	mem_bus_if dbus ();

	icache icache_i (
		.clk(clk),
		.reset(reset),
		.i_read(i_read),
		.i_address(i_address),
		.i_resp(i_resp),
		.i_rdata(i_rdata),
		.bus(ibus.client)
	);

	dcache dcache_i (
		.clk(clk),
		.reset(reset),
		.d_read(d_read),
		.d_write(d_write),
		.d_address(d_address),
		.d_wdata(d_wdata),
		.d_byte_enable(d_byte_enable),
		.d_resp(d_resp),
		.d_rdata(d_rdata),
		.bus(dbus.client)
	);

	// The two caches never share lines, so no snooping is needed here.
	mem_arbiter arbiter_i (
		.clk(clk),
		.reset(reset),
		.ibus(ibus.server),
		.dbus(dbus.server),
		.pmem_read(pmem_read),
		.pmem_write(pmem_write),
		.pmem_address(pmem_address),
		.pmem_wdata(pmem_wdata),
		.pmem_resp(pmem_resp),
		.pmem_rdata(pmem_rdata)
	);

endmodule : memsys_top

//--- tests/phys_mem_model.sv
`timescale 1ns/1ns

module phys_mem_model import memsys_pkg::*; (
	input logic clk,
	input logic reset,
	input logic [3:0] latency,  // Cycles from the request to resp (1 to 8).

	input logic pmem_read,
	input logic pmem_write,
	input word_t pmem_address,
	input block_t pmem_wdata,
	output logic pmem_resp,
	output block_t pmem_rdata
);

	block_t lines [2048];  // One entry per line indexed by address bits 15 to 5.
	logic busy;
	logic [3:0] count;
	logic [10:0] line_sel;

	// Each word starts with a value mixed from its own address.
	function automatic word_t fill_value(word_t a);
		return {a[7:0], a[15:8]} ^ (a + 16'h3c5a);
	endfunction

	initial begin
		for (int i = 0; i < 2048; i++) begin
			for (int w = 0; w < 16; w++)
				lines[i][w*16 +: 16] = fill_value({11'(i), 4'(w), 1'b0});
		end
	end

	assign line_sel = pmem_address[15:5];

	always @(posedge clk) begin
		pmem_resp <= 1'b0;
		if (reset) begin
			busy <= 1'b0;
		end else if (busy) begin
			if (count <= 4'd1) begin
				busy <= 1'b0;
				pmem_resp <= 1'b1;
				if (pmem_write)
					lines[line_sel] <= pmem_wdata;  // The whole line is replaced.
				else
					pmem_rdata <= lines[line_sel];
			end else begin
				count <= count - 4'd1;
			end
		end else if ((pmem_read || pmem_write) && !pmem_resp) begin
			// The request stays up until resp, so it is served at the end of the count.
			busy <= 1'b1;
			count <= latency;
		end
	end

endmodule : phys_mem_model

//--- tests/tb_memsys.sv
`timescale 1ns/1ns

module tb_memsys import memsys_pkg::*; ();

	logic clk = 1'b0;
	logic reset;
	logic i_read;
	word_t i_address;
	logic i_resp;
	word_t i_rdata;
	logic d_read;
	logic d_write;
	word_t d_address;
	word_t d_wdata;
	wmask_t d_byte_enable;
	logic d_resp;
	word_t d_rdata;
	logic pmem_read;
	logic pmem_write;
	word_t pmem_address;
	block_t pmem_wdata;
	logic pmem_resp;
	block_t pmem_rdata;
	logic [3:0] mem_latency;

	logic [15:0] lfsr;
	word_t written [word_t];  // Words stored so far. All others still hold the preload.
	int error_count = 0;
	int idle_pmem_errors = 0;
	int tests_failed = 0;

	memsys_top dut_i (.*);
	phys_mem_model mem_i (.*, .latency(mem_latency));

	always #4 clk = ~clk;

	// Memory traffic is only allowed on behalf of a waiting client.
	always @(negedge clk) begin
		if (!reset && (pmem_read || pmem_write) && !(i_read || d_read || d_write)) begin
			$display("Memory request seen with no client request pending at %0t", $time);
			idle_pmem_errors++;
		end
	end

	// Galois LFSR that is stepped once for every bit taken.
	function automatic word_t draw(int n);
		word_t v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};
			lfsr = (lfsr >> 1) ^ (lfsr[0] ? 16'hb400 : 16'h0000);
		end
		return v;
	endfunction

	// Reference memory. An untouched word keeps the value mixed from its address.
	function automatic word_t expected_word(word_t a);
		return written.exists(a) ? written[a] : ({a[7:0], a[15:8]} ^ (a + 16'h3c5a));
	endfunction

	task automatic check_word(string name, word_t expected, word_t actual);
		if (actual !== expected) begin
			$display("Error %s: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	// Holds one request on the instruction side (port 0) or data side (port 1) until resp.
	task automatic access(input logic port, input logic wr, input word_t addr,
			input word_t wdata, input wmask_t be, output word_t data, output int cycles);
		logic resp;
		if (port) begin
			d_read = !wr;
			d_write = wr;
			d_address = addr;
			d_wdata = wdata;
			d_byte_enable = be;
		end else begin
			i_read = 1'b1;
			i_address = addr;
		end
		cycles = 0;
		resp = 1'b0;
		while (!resp && cycles < 200) begin
			@(posedge clk);
			#1;
			cycles++;
			resp = port ? d_resp : i_resp;
		end
		if (!resp) begin
			$display("No response within 200 cycles to the request at %h", addr);
			error_count++;
		end
		data = port ? d_rdata : i_rdata;
		if (port) begin
			d_read = 1'b0;
			d_write = 1'b0;
		end else begin
			i_read = 1'b0;
		end
	endtask

	// A load is compared with the reference. A store updates only its enabled bytes.
	task automatic op_checked(string name, logic port, logic wr, word_t addr,
			word_t wdata, wmask_t be);
		word_t data;
		word_t old;
		int cycles;
		access(port, wr, addr, wdata, be, data, cycles);
		old = expected_word(addr);
		if (wr)
			written[addr] = {be[1] ? wdata[15:8] : old[15:8], be[0] ? wdata[7:0] : old[7:0]};
		else
			check_word(name, old, data);
	endtask

	task automatic end_test(string name, int errors_before);
		if (error_count == errors_before) begin
			$display("%s: ok", name);
		end else begin
			tests_failed++;
			$display("%s: %0d errors", name, error_count - errors_before);
		end
	endtask

	initial begin
		int errs;
		int cycles;
		logic port;
		logic wr;
		wmask_t be;
		word_t base;
		word_t addr;
		word_t data;
		block_t line;

		lfsr = 16'd45;
		reset = 1'b1;
		i_read = 1'b0;
		i_address = '0;
		d_read = 1'b0;
		d_write = 1'b0;
		d_address = '0;
		d_wdata = '0;
		d_byte_enable = '0;
		mem_latency = 4'd1;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;

		errs = error_count;
		repeat (10) begin
			@(posedge clk);
			#1;
			if ({i_resp, d_resp, pmem_read, pmem_write} !== 4'b0000) begin
				$display("Error reset_state: expected 0000, actual %b%b%b%b",
					i_resp, d_resp, pmem_read, pmem_write);
				error_count++;
			end
		end
		end_test("reset_state", errs);

		errs = error_count;
		repeat (64) begin
			mem_latency = 4'(draw(3)) + 4'd1;
			op_checked("instruction_reads", 1'b0, 1'b0, {2'b00, 13'(draw(13)), 1'b0}, '0, '0);
		end
		end_test("instruction_reads", errs);

		// One idle cycle follows the fill so the second request is sampled at the next edge.
		errs = error_count;
		for (int n = 0; n < 8; n++) begin
			port = 1'(n);
			mem_latency = 4'(draw(3)) + 4'd1;
			base = {1'b0, port, 13'(draw(13)), 1'b0};
			op_checked("hit_timing", port, 1'b0, base, '0, '0);
			@(posedge clk);
			#1;
			addr = {base[15:5], 4'(draw(4)), 1'b0};
			access(port, 1'b0, addr, '0, '0, data, cycles);
			check_word("hit_timing", expected_word(addr), data);
			if (cycles != 1) begin
				$display("Error hit_timing: expected 1 cycle, actual %0d cycles", cycles);
				error_count++;
			end
		end
		end_test("hit_timing", errs);

		errs = error_count;
		repeat (64) begin
			mem_latency = 4'(draw(3)) + 4'd1;
			wr = 1'(draw(1));
			addr = {5'b01000, 3'(draw(3)), 3'(draw(3)), 4'(draw(4)), 1'b0};
			data = draw(16);
			be = 2'(draw(2));
			op_checked("byte_writes", 1'b1, wr, addr, data, be);
		end
		end_test("byte_writes", errs);

		// Dirty the line, then read a different tag at the same index to evict it.
		errs = error_count;
		repeat (3) begin
			mem_latency = 4'(draw(3)) + 4'd1;
			base = {5'b01001, 3'(draw(3)), 3'(draw(3)), 5'b00000};
			repeat (4)
				op_checked("writeback", 1'b1, 1'b1, {base[15:5], 4'(draw(4)), 1'b0},
					draw(16), 2'b11);
			op_checked("writeback", 1'b1, 1'b0, base ^ 16'h0800, '0, '0);
			line = mem_i.lines[base[15:5]];
			for (int w = 0; w < 16; w++) begin
				addr = {base[15:5], 4'(w), 1'b0};
				check_word("writeback_memory", expected_word(addr), line[w*16 +: 16]);
				op_checked("writeback", 1'b1, 1'b0, addr, '0, '0);
			end
		end
		end_test("writeback", errs);

		errs = error_count;
		repeat (32) begin
			mem_latency = 4'(draw(3)) + 4'd1;
			addr = {2'b00, 13'(draw(13)), 1'b0};
			base = {5'b01000, 3'(draw(3)), 3'(draw(3)), 4'(draw(4)), 1'b0};
			data = draw(16);
			wr = 1'(draw(1));
			be = 2'(draw(2));
			fork
				op_checked("contention", 1'b0, 1'b0, addr, '0, '0);
				op_checked("contention", 1'b1, wr, base, data, be);
			join
		end
		error_count += idle_pmem_errors;
		end_test("contention", errs);

		$display("6 tests, %0d failed, %0d errors", tests_failed, error_count);
		if (error_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule : tb_memsys

//--- sim.f
+incdir+logic
logic/memsys_pkg.sv
logic/mem_bus_if.sv
logic/icache.sv
logic/dcache.sv
logic/mem_arbiter.sv
logic/memsys_top.sv
tests/phys_mem_model.sv
tests/tb_memsys.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sim.f --top-module tb_memsys -Mdir obj_dir -o tb_memsys &&
out=$(./obj_dir/tb_memsys) &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx "Test passed" ||
{ echo "Simulation failed"; exit 1; }
